/* tb.f */
src/cuPkg.sv
src/decodeIf.sv
src/stepIf.sv
src/instrDecoder.sv
src/microSequencer.sv
src/controlEncoder.sv
src/controlUnit.sv
bench/cuHandshake_checker.sv
bench/cuScoreboard.sv
bench/tbControlUnit.sv

/* Bender.yml */
package:
  name: control_unit

sources:
  - src/cuPkg.sv
  - src/decodeIf.sv
  - src/stepIf.sv
  - src/instrDecoder.sv
  - src/microSequencer.sv
  - src/controlEncoder.sv
  - src/controlUnit.sv
  - target: test
    files:
      - bench/cuHandshake_checker.sv
      - bench/cuScoreboard.sv
      - bench/tbControlUnit.sv

/* bench/tbControlUnit.sv */
`timescale 1ns/10ps

module tbControlUnit;
	localparam int NUM_INSTR  = 64;
	localparam int WAIT_LIMIT = 200;

	logic        clk;
	logic        rst;
	logic [31:0] memData;
	logic        cond;
	logic        moc;
	logic        memFa;
	logic        memRead;
	logic        regWrite;
	logic        flagWrite;
	logic        addrWriteback;
	logic        aluSub;
	logic        byteMode;
	logic        illegal;
	logic        instrDone;
	logic        pushValid;
	logic [31:0] pushWord;
	logic        pushCond;
	int          checkedCount;
	int          errorCount;
	logic        timedOut;
	logic        respFail;
	logic [31:0] instrQueue[$];
	logic        condQueue[$];
	int          delayQueue[$];

	controlUnit dut (.*);

	cuScoreboard board (.*);

	always #10 clk = ~clk;

	// One category per kind, other fields random
	function automatic logic [31:0] makeInstr(input int kind);
		logic [31:0] w;
		w = $urandom();
		case (kind)
			0: w[27:25] = 3'b001;  // Data processing, immediate
			1: begin
				w[27:25] = 3'b000;  // Register operand, immediate shift
				w[4] = 1'b0;
			end
			2: begin
				w[27:25] = 3'b001;
				w[24:21] = 4'($urandom_range(8, 9));  // TST or TEQ
				w[20] = 1'b1;
			end
			3: w[27:25] = 3'b010;  // LDR/STR immediate offset
			4: begin
				w[27:25] = 3'b011;  // Register offset
				w[4] = 1'b0;
			end
			5: begin
				w[27:25] = 3'b000;  // Shift by register
				w[7] = 1'b0;
				w[4] = 1'b1;
			end
			6: begin
				w[27:25] = 3'b000;  // Halfword and signed transfers
				w[7] = 1'b1;
				w[6:5] = 2'($urandom_range(1, 3));
				w[4] = 1'b1;
			end
			default: w[27:25] = 3'($urandom_range(4, 5));  // LDM/STM or branch
		endcase
		return w;
	endfunction

	initial begin : mainFlow
		int seedValue;
		int cycles;
		seedValue = $urandom(32'h3072_c3ef);
		clk = 1'b0;
		rst = 1'b1;
		memData = '0;
		cond = 1'b0;
		moc = 1'b0;
		pushValid = 1'b0;
		pushWord = '0;
		pushCond = 1'b0;
		respFail = 1'b0;
		for (int n = 0; n < NUM_INSTR; n++) begin
			instrQueue.push_back(makeInstr(n % 8));
			condQueue.push_back($urandom_range(0, 3) != 0);  // Mostly executed
			// Raise and release delays of the fetch and the data access
			repeat (4)
				delayQueue.push_back($urandom_range(0, 3));
		end
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		cycles = 0;
		while (checkedCount < NUM_INSTR && !timedOut && !respFail
			&& cycles < NUM_INSTR * WAIT_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (cycles >= NUM_INSTR * WAIT_LIMIT)
			$display("ERROR: run did not finish within %0d cycles", NUM_INSTR * WAIT_LIMIT);
		$display("Checked %0d of %0d instructions, %0d errors, %0d assertion failures",
			checkedCount, NUM_INSTR, errorCount, dut.handshakeCheck.failCount);
		if (checkedCount == NUM_INSTR && errorCount == 0 && !timedOut && !respFail
			&& dut.handshakeCheck.failCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Memory side of the four-phase handshake
	initial begin : memResponder
		int   cycles;
		int   delay;
		logic fetchNext;
		logic running;
		fetchNext = 1'b1;
		running = 1'b1;
		while (running) begin
			cycles = 0;
			do begin
				@(posedge clk);
				#1;
				cycles++;
				if (instrDone)
					fetchNext = 1'b1;  // Next request is a fetch
			end while (!memFa && cycles < WAIT_LIMIT);
			if (!memFa) begin
				$display("ERROR: no memory request within %0d cycles", WAIT_LIMIT);
				respFail = 1'b1;
				running = 1'b0;
			end else if (fetchNext && instrQueue.size() == 0) begin
				running = 1'b0;  // Last fetch stays pending
			end else begin
				delay = (delayQueue.size() > 0) ? delayQueue.pop_front() : 0;
				repeat (delay) begin
					@(posedge clk);
					#1;
				end
				if (fetchNext) begin
					memData = instrQueue.pop_front();
					cond = condQueue.pop_front();
					pushWord = memData;
					pushCond = cond;
					pushValid = 1'b1;
				end
				fetchNext = 1'b0;
				moc = 1'b1;
				cycles = 0;
				do begin
					@(posedge clk);
					#1;
					cycles++;
					pushValid = 1'b0;
				end while (memFa && cycles < WAIT_LIMIT);
				if (memFa) begin
					$display("ERROR: memFa still high %0d cycles after moc", WAIT_LIMIT);
					respFail = 1'b1;
					running = 1'b0;
				end else begin
					// Slow release, the controller must wait for moc low
					delay = (delayQueue.size() > 0) ? delayQueue.pop_front() : 0;
					repeat (delay) begin
						@(posedge clk);
						#1;
						if (instrDone)
							fetchNext = 1'b1;
					end
				end
				moc = 1'b0;
			end
		end
	end

endmodule

/* bench/cuScoreboard.sv */
`timescale 1ns/10ps

module cuScoreboard (
	input  logic        clk,
	input  logic        memFa,
	input  logic        memRead,
	input  logic        regWrite,
	input  logic        flagWrite,
	input  logic        addrWriteback,
	input  logic        aluSub,
	input  logic        byteMode,
	input  logic        illegal,
	input  logic        instrDone,
	input  logic        pushValid,
	input  logic [31:0] pushWord,
	input  logic        pushCond,
	output int          checkedCount,
	output int          errorCount,
	output logic        timedOut
);
	localparam int WAIT_LIMIT = 200;
	localparam int NUM_FIELDS = 8;

	// Handshakes, six pulse counts, then memRead of the data access
	typedef logic [NUM_FIELDS-1:0][3:0] summary_t;

	string       fieldNames [NUM_FIELDS];
	logic [31:0] wordQueue[$];
	logic        condQueue[$];
	summary_t    seen;
	logic [6:0]  prevLevels;

	// Expected activity of one instruction, from its ARM encoding
	function automatic summary_t expectedSummary(input logic [31:0] word, input logic condOk);
		summary_t s;
		logic     isDp;
		logic     isLs;
		logic     testOnly;
		s = '0;
		s[0] = 4'd1;  // Fetch
		isDp = (word[27:25] == 3'b001) || (word[27:25] == 3'b000 && !word[4]);
		isLs = (word[27:25] == 3'b010) || (word[27:25] == 3'b011 && !word[4]);
		testOnly = (word[24:21] == 4'b1000) || (word[24:21] == 4'b1001);
		if (condOk && isDp) begin
			s[1] = 4'(!testOnly);
			s[2] = 4'(testOnly || word[20]);
		end else if (condOk && isLs) begin
			s[0] = 4'd2;
			s[1] = 4'(word[20]);  // Load writes Rd
			s[3] = 4'(!word[24] || word[21]);  // Post-index or writeback
			s[4] = 4'(!word[23]);
			s[5] = 4'(word[22]);
			s[7] = 4'(word[20]);
		end else if (condOk) begin
			s[6] = 4'd1;
		end
		return s;
	endfunction

	// Counts rising edges, so a held line is one pulse
	task automatic sampleCycle();
		logic [6:0] now;
		now = {illegal, byteMode, aluSub, addrWriteback, flagWrite, regWrite, memFa};
		if (pushValid) begin
			wordQueue.push_back(pushWord);
			condQueue.push_back(pushCond);
		end
		for (int i = 0; i < 7; i++) begin
			if (now[i] && !prevLevels[i])
				seen[i] = seen[i] + 4'd1;
		end
		if (memFa && !prevLevels[0] && seen[0] == 4'd2)
			seen[7] = 4'(memRead);  // Direction of the data access
		prevLevels = now;
	endtask

	initial begin : compareFlow
		int          cycles;
		summary_t    expVals;
		logic [31:0] word;
		logic        wordCond;
		logic        ok;
		fieldNames = '{"handshakes", "regWrite", "flagWrite", "addrWriteback", "aluSub",
			"byteMode", "illegal", "memRead"};
		checkedCount = 0;
		errorCount = 0;
		timedOut = 1'b0;
		seen = '0;
		prevLevels = '0;
		while (!timedOut) begin
			cycles = 0;
			do begin
				@(negedge clk);  // Mid-cycle, outputs are settled
				cycles++;
				sampleCycle();
			end while (!instrDone && cycles < WAIT_LIMIT);
			if (!instrDone) begin
				$display("ERROR: no instrDone within timeout of %0d cycles", WAIT_LIMIT);
				timedOut = 1'b1;
				errorCount++;
			end else if (wordQueue.size() == 0) begin
				$display("ERROR: instrDone without a fetched instruction");
				errorCount++;
			end else begin
				word = wordQueue.pop_front();
				wordCond = condQueue.pop_front();
				expVals = expectedSummary(word, wordCond);
				ok = 1'b1;
				for (int i = 0; i < NUM_FIELDS; i++) begin
					if (seen[i] !== expVals[i]) begin
						$display("MISMATCH %s: expected 0x%h, got 0x%h", fieldNames[i],
							expVals[i], seen[i]);
						ok = 1'b0;
					end
				end
				if (!ok)
					errorCount++;
				$display("instr %0d word 0x%h cond %b: %s", checkedCount, word, wordCond,
					ok ? "ok" : "error");
				checkedCount++;
			end
			seen = '0;
		end
	end

endmodule

/* bench/cuHandshake_checker.sv */
`timescale 1ns/10ps

module cuHandshake_checker (
	input logic clk,
	input logic rst,
	input logic moc,
	input logic memFa,
	input logic memRead,
	input logic regWrite,
	input logic flagWrite,
	input logic addrWriteback,
	input logic aluSub,
	input logic byteMode,
	input logic illegal,
	input logic instrDone
);

	int failCount = 0;  // Failed assertions so far

	// A new request waits until the last acknowledge is gone
	assert property (@(posedge clk) disable iff (rst) $rose(memFa) |-> !$past(moc))
		else begin
			$error("memFa rose while moc was still high");
			failCount++;
		end

	assert property (@(posedge clk) disable iff (rst) $fell(memFa) |-> $past(moc))
		else begin
			$error("memFa dropped before moc was seen");
			failCount++;
		end

	assert property (@(posedge clk) disable iff (rst) !(illegal && regWrite))
		else begin
			$error("illegal and regWrite high together");
			failCount++;
		end

	// Step register is cleared by the first reset edge
	assert property (@(posedge clk) rst && $past(rst) |-> !(memFa || memRead || regWrite
		|| flagWrite || addrWriteback || aluSub || byteMode || illegal || instrDone))
		else begin
			$error("control output high during reset");
			failCount++;
		end

endmodule

bind controlUnit cuHandshake_checker handshakeCheck (.*);

/* src/controlUnit.sv */
`timescale 1ns/10ps

module controlUnit (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [cuPkg::WORD_WIDTH-1:0] memData,
	input  logic                         cond,
	input  logic                         moc,
	output logic                         memFa,
	output logic                         memRead,
	output logic                         regWrite,
	output logic                         flagWrite,
	output logic                         addrWriteback,
	output logic                         aluSub,
	output logic                         byteMode,
	output logic                         illegal,
	output logic                         instrDone
);

	decodeIf decBus ();  // Decoder to sequencer
	stepIf   stepBus ();  // Sequencer to encoder

	instrDecoder uDecoder (
		.clk     (clk),
		.rst     (rst),
		.memData (memData),
		.dIf     (decBus.dec)
	);

	microSequencer uSequencer (
		.clk  (clk),
		.rst  (rst),
		.cond (cond),
		.moc  (moc),
		.dIf  (decBus.seq),
		.sIf  (stepBus.seq)
	);

	controlEncoder uEncoder (
		.sIf           (stepBus.enc),
		.memFa         (memFa),
		.memRead       (memRead),
		.regWrite      (regWrite),
		.flagWrite     (flagWrite),
		.addrWriteback (addrWriteback),
		.aluSub        (aluSub),
		.byteMode      (byteMode),
		.illegal       (illegal),
		.instrDone     (instrDone)
	);

endmodule

/* src/controlEncoder.sv */
`timescale 1ns/10ps

module controlEncoder (
	stepIf.enc   sIf,
	output logic memFa,
	output logic memRead,
	output logic regWrite,
	output logic flagWrite,
	output logic addrWriteback,
	output logic aluSub,
	output logic byteMode,
	output logic illegal,
	output logic instrDone
);
	import cuPkg::*;

	logic inFetch;
	logic inDecode;
	logic inAlu;
	logic inMem;
	logic inWb;
	logic isIllegal;

	assign inFetch   = (sIf.step == StFetch) && sIf.active;
	assign inDecode  = (sIf.step == StDecode);
	assign inAlu     = (sIf.step == StAluOp);
	assign inMem     = (sIf.step == StMemAccess);
	assign inWb      = (sIf.step == StWriteBack);
	assign isIllegal = (sIf.instrClass == ClsIllegal);

	// Request is held until moc, so memFa follows the access steps
	assign memFa   = inFetch || inMem;
	assign memRead = inFetch || (inMem && sIf.isLoad);

	assign regWrite = (inAlu && sIf.instrClass != ClsDataTest)
		|| (inWb && sIf.isLoad);  // Load data to Rd
	assign flagWrite = inAlu && (sIf.instrClass == ClsDataTest || sIf.setFlags);

	assign addrWriteback = inWb && (sIf.indexMode != IdxOffset);  // Base update
	assign aluSub        = (sIf.step == StAddrCalc) && sIf.subtract;
	assign byteMode      = inMem && sIf.isByte;

	assign illegal = inDecode && !sIf.skip && isIllegal;

	// Last step of each path
	assign instrDone = inAlu || inWb || (inDecode && (sIf.skip || isIllegal));

endmodule

/* src/microSequencer.sv */
`timescale 1ns/10ps

module microSequencer (
	input  logic clk,
	input  logic rst,
	input  logic cond,
	input  logic moc,
	decodeIf.seq dIf,
	stepIf.seq   sIf
);
	import cuPkg::*;

	seqStep_t step;
	seqStep_t nextStep;
	logic     active;
	logic     decodeEntry;

	// Holds off the first fetch until reset is released
	always_ff @(posedge clk) begin
		if (rst)
			active <= 1'b0;
		else
			active <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst)
			step <= StFetch;
		else
			step <= nextStep;
	end

	always_comb begin
		nextStep = step;
		case (step)
			StFetch: begin
				if (active && moc)
					nextStep = StFetchRelease;
			end
			StFetchRelease: begin
				if (!moc)
					nextStep = StDecode;
			end
			StDecode: begin
				if (!cond || sIf.instrClass == ClsIllegal)
					nextStep = StFetch;  // Skip or report, then next fetch
				else if (sIf.instrClass == ClsLoadStore)
					nextStep = StAddrCalc;
				else
					nextStep = StAluOp;
			end
			StAluOp:
				nextStep = StFetch;
			StAddrCalc:
				nextStep = StMemAccess;
			StMemAccess: begin
				if (moc)
					nextStep = StMemRelease;
			end
			StMemRelease: begin
				if (!moc)
					nextStep = StWriteBack;
			end
			StWriteBack:
				nextStep = StFetch;
			default:
				nextStep = StFetch;
		endcase
	end

	// Instruction word is valid on memData while moc is high
	assign dIf.irCapture = (step == StFetch) && active && moc;

	// Attributes are loaded on the edge into StDecode and held to the end
	assign decodeEntry = (step == StFetchRelease) && !moc;

	always_ff @(posedge clk) begin
		if (rst) begin
			sIf.instrClass <= ClsDataProc;
			sIf.setFlags   <= 1'b0;
			sIf.isLoad     <= 1'b0;
			sIf.isByte     <= 1'b0;
			sIf.subtract   <= 1'b0;
			sIf.indexMode  <= IdxOffset;
		end else if (decodeEntry) begin
			sIf.instrClass <= dIf.instrClass;
			sIf.setFlags   <= dIf.setFlags;
			sIf.isLoad     <= dIf.isLoad;
			sIf.isByte     <= dIf.isByte;
			sIf.subtract   <= dIf.subtract;
			sIf.indexMode  <= dIf.indexMode;
		end
	end

	assign sIf.step   = step;
	assign sIf.active = active;
	assign sIf.skip   = ~cond;  // Only looked at in StDecode

endmodule

/* src/instrDecoder.sv */
`timescale 1ns/10ps

module instrDecoder (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [cuPkg::WORD_WIDTH-1:0] memData,
	decodeIf.dec                         dIf
);
	import cuPkg::*;

	logic [WORD_WIDTH-1:0] ir;
	logic                  irValid;
	logic [2:0]            clsField;
	logic [3:0]            opcode;
	logic                  testOpc;
	logic                  shiftByReg;
	logic                  extForm;

	// Instruction register
	always_ff @(posedge clk) begin
		if (dIf.irCapture)
			ir <= memData;
	end

	always_ff @(posedge clk) begin
		if (rst)
			irValid <= 1'b0;
		else if (dIf.irCapture)
			irValid <= 1'b1;
	end

	assign clsField = ir[CLASS_MSB:CLASS_LSB];
	assign opcode   = ir[OPCODE_MSB:OPCODE_LSB];
	assign testOpc  = (opcode == OPC_TST) || (opcode == OPC_TEQ);

	// Bit 4 set in class 000 is shift-by-register, or the extra load/store
	// space when bit 7 is also set
	assign shiftByReg = ~ir[BIT_7] & ir[BIT_SHIFTREG];
	assign extForm    = ir[BIT_7] & ir[BIT_SHIFTREG];

	always_comb begin
		dIf.instrClass = ClsIllegal;
		if (irValid) begin
			case (clsField)
				CLS_DP_REG: begin
					if (!shiftByReg && !extForm)
						dIf.instrClass = testOpc ? ClsDataTest : ClsDataProc;
				end
				CLS_DP_IMM:
					dIf.instrClass = testOpc ? ClsDataTest : ClsDataProc;
				CLS_LS_IMM:
					dIf.instrClass = ClsLoadStore;
				CLS_LS_REG: begin
					if (!ir[BIT_SHIFTREG])  // Bit 4 set is a media op
						dIf.instrClass = ClsLoadStore;
				end
				default:
					dIf.instrClass = ClsIllegal;  // Multiple, branch, coprocessor
			endcase
		end
	end

	assign dIf.setFlags = ir[BIT_S];
	assign dIf.isLoad   = ir[BIT_L];
	assign dIf.isByte   = ir[BIT_B];
	assign dIf.subtract = ~ir[BIT_U];

	always_comb begin
		if (!ir[BIT_P])
			dIf.indexMode = IdxPost;
		else if (ir[BIT_W])
			dIf.indexMode = IdxPre;
		else
			dIf.indexMode = IdxOffset;
	end

endmodule

/* src/stepIf.sv */
`timescale 1ns/10ps

interface stepIf;
	import cuPkg::*;

	seqStep_t    step;
	logic        active;  // Low until the first cycle after reset
	logic        skip;    // Condition failed
	instrClass_t instrClass;
	logic        setFlags;
	logic        isLoad;
	logic        isByte;
	logic        subtract;
	indexMode_t  indexMode;

	modport seq (output step, active, skip, instrClass, setFlags, isLoad, isByte,
		subtract, indexMode);

	modport enc (input step, active, skip, instrClass, setFlags, isLoad, isByte,
		subtract, indexMode);

endinterface

/* src/decodeIf.sv */
`timescale 1ns/10ps

interface decodeIf;
	import cuPkg::*;

	logic        irCapture;  // Load instruction register
	instrClass_t instrClass;
	logic        setFlags;
	logic        isLoad;
	logic        isByte;
	logic        subtract;
	indexMode_t  indexMode;

	modport dec (
		input  irCapture,
		output instrClass, setFlags, isLoad, isByte, subtract, indexMode
	);

	modport seq (
		output irCapture,
		input  instrClass, setFlags, isLoad, isByte, subtract, indexMode
	);

endinterface

/* src/cuPkg.sv */
package cuPkg;

	localparam int WORD_WIDTH = 32;

	// Instruction field positions
	localparam int CLASS_MSB    = 27;
	localparam int CLASS_LSB    = 25;
	localparam int OPCODE_MSB   = 24;
	localparam int OPCODE_LSB   = 21;
	localparam int BIT_S        = 20;  // Set flags, data processing
	localparam int BIT_L        = 20;  // Load, transfers
	localparam int BIT_P        = 24;  // Pre-index
	localparam int BIT_U        = 23;  // Up, add offset
	localparam int BIT_B        = 22;  // Byte transfer
	localparam int BIT_W        = 21;  // Writeback
	localparam int BIT_SHIFTREG = 4;   // Shift amount from register
	localparam int BIT_7        = 7;

	// Opcodes that only write flags
	localparam logic [3:0] OPC_TST = 4'b1000;
	localparam logic [3:0] OPC_TEQ = 4'b1001;

	// Codes of the class field for the supported formats
	localparam logic [2:0] CLS_DP_REG = 3'b000;
	localparam logic [2:0] CLS_DP_IMM = 3'b001;
	localparam logic [2:0] CLS_LS_IMM = 3'b010;
	localparam logic [2:0] CLS_LS_REG = 3'b011;

	typedef enum logic [1:0] {
		ClsDataProc,
		ClsDataTest,
		ClsLoadStore,
		ClsIllegal
	} instrClass_t;

	typedef enum logic [1:0] {
		IdxOffset,
		IdxPre,   // Pre-index with writeback
		IdxPost
	} indexMode_t;

	typedef enum logic [2:0] {
		StFetch,
		StFetchRelease,
		StDecode,
		StAluOp,
		StAddrCalc,
		StMemAccess,
		StMemRelease,
		StWriteBack
	} seqStep_t;

endpackage
